//--- hdl/cpu_pkg.sv
package cpu_pkg;

	localparam int ROB_WIDTH  = 4;
	localparam int DATA_WIDTH = 32;

	typedef logic [ROB_WIDTH-1:0] rob_tag_t;

	// bus value, or an operand where valid means data present
	typedef struct packed {
		logic                  valid;
		rob_tag_t              tag;
		logic [DATA_WIDTH-1:0] data;
	} cdb_t;

	// capture the broadcast when a pending operand's tag shows up
	function automatic cdb_t wake(cdb_t opd, cdb_t bus);
		cdb_t r;
		r = opd;
		if (!opd.valid && bus.valid && bus.tag == opd.tag) begin
			r.valid = 1'b1;
			r.data  = bus.data;
		end
		return r;
	endfunction

endpackage

//--- hdl/lsu_pkg.sv
package lsu_pkg;

	localparam int ADDR_WIDTH   = 10;  // word address
	localparam int N_AGU        = 2;
	localparam int N_LQ         = 2;
	localparam int N_SQ         = 4;
	localparam int SQ_PTR_WIDTH = 3;   // holds 0..N_SQ
	localparam int LQ_PTR_WIDTH = 1;

	typedef enum logic {MEM_LOAD, MEM_STORE} mem_kind_t;

	typedef struct packed {
		mem_kind_t             kind;
		logic                  imm_addr;
		logic [ADDR_WIDTH-1:0] addr_imm;  // absolute address, or signed offset
		cpu_pkg::cdb_t         base;
		cpu_pkg::cdb_t         store_data;
		cpu_pkg::rob_tag_t     dest;
	} lsu_issue_t;

	typedef struct packed {
		logic                    valid;
		mem_kind_t               kind;
		logic [SQ_PTR_WIDTH-1:0] pointer;  // slot in the target queue
		logic [ADDR_WIDTH-1:0]   offset;
		cpu_pkg::cdb_t           base;
	} agu_entry_t;

	typedef struct packed {
		logic                    valid;
		mem_kind_t               kind;
		logic [SQ_PTR_WIDTH-1:0] slot;
		logic [ADDR_WIDTH-1:0]   addr;
	} agu_wb_t;

	typedef struct packed {
		cpu_pkg::rob_tag_t       tag;
		logic                    addr_valid;
		logic [ADDR_WIDTH-1:0]   addr;          // offset until the AGU writes back
		logic [SQ_PTR_WIDTH-1:0] older_stores;
	} load_entry_t;

	typedef struct packed {
		logic                  addr_valid;
		logic [ADDR_WIDTH-1:0] addr;
		cpu_pkg::cdb_t         data;
	} store_entry_t;

endpackage

//--- hdl/addr_gen_unit.sv
`timescale 1ns/1ps

module addr_gen_unit import cpu_pkg::*, lsu_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  lsu_issue_t              issue,
	input  logic                    issue_valid,
	input  cdb_t                    cdb,
	input  logic                    lq_room,
	input  logic                    sq_room,
	input  logic [LQ_PTR_WIDTH:0]   lq_count,
	input  logic [SQ_PTR_WIDTH-1:0] sq_count,
	input  logic                    lq_dequeue,
	input  logic                    sq_commit,
	input  logic [ADDR_WIDTH-1:0]   lq_base_addr [N_LQ],
	input  store_entry_t            sq_entries [N_SQ],
	output logic                    issue_ready,
	output logic                    issue_accept,
	output agu_wb_t                 agu_wb
);

	agu_entry_t ent [N_AGU];  // packed toward slot 0
	agu_entry_t upd [N_AGU];
	agu_entry_t nxt [N_AGU];
	agu_entry_t new_entry;
	logic [ADDR_WIDTH-1:0] slot_addr [N_AGU];
	logic dispatch;
	logic sel;  // entry being dispatched
	logic agu_room;
	logic queue_room;

	always_comb begin
		new_entry.valid  = issue_accept && !issue.imm_addr;
		new_entry.kind   = issue.kind;
		new_entry.offset = issue.addr_imm;
		new_entry.base   = wake(issue.base, cdb);
		// lands behind whatever survives this edge
		if (issue.kind == MEM_LOAD)
			new_entry.pointer = SQ_PTR_WIDTH'(lq_count) - SQ_PTR_WIDTH'(lq_dequeue);
		else
			new_entry.pointer = sq_count - SQ_PTR_WIDTH'(sq_commit);
	end

	always_comb begin
		for (int j = 0; j < N_AGU; j++) begin
			upd[j]      = ent[j];
			upd[j].base = wake(ent[j].base, cdb);
			if (ent[j].kind == MEM_LOAD)
				upd[j].pointer = ent[j].pointer - SQ_PTR_WIDTH'(lq_dequeue);
			else
				upd[j].pointer = ent[j].pointer - SQ_PTR_WIDTH'(sq_commit);

			// the queue slot still holds the raw offset
			if (ent[j].kind == MEM_LOAD)
				slot_addr[j] = lq_base_addr[ent[j].pointer[LQ_PTR_WIDTH-1:0]];
			else
				slot_addr[j] = sq_entries[ent[j].pointer[$clog2(N_SQ)-1:0]].addr;
		end
	end

	// oldest ready entry wins
	assign dispatch = (ent[0].valid && ent[0].base.valid) ||
		(ent[1].valid && ent[1].base.valid);
	assign sel = !(ent[0].valid && ent[0].base.valid);

	always_comb begin
		agu_wb.valid = dispatch;
		agu_wb.kind  = ent[sel].kind;
		agu_wb.slot  = ent[sel].pointer;
		agu_wb.addr  = ent[sel].base.data[ADDR_WIDTH-1:0] + slot_addr[sel];
	end

	always_comb begin
		nxt[0] = ent[0].valid ? upd[0] : new_entry;
		nxt[1] = ent[1].valid ? upd[1] : new_entry;
		if (!ent[0].valid)
			nxt[1].valid = 1'b0;
		if (dispatch) begin
			if (!sel) begin
				nxt[0] = ent[1].valid ? upd[1] : new_entry;
				nxt[1] = new_entry;
				if (!ent[1].valid)
					nxt[1].valid = 1'b0;
			end else begin
				nxt[1] = new_entry;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < N_AGU; j++) begin
			ent[j] <= nxt[j];
			if (reset)
				ent[j].valid <= 1'b0;
		end
	end

	assign agu_room = issue.imm_addr || dispatch || !ent[N_AGU-1].valid;  // immediates skip the station
	assign queue_room = (issue.kind == MEM_LOAD) ? lq_room : sq_room;
	assign issue_ready = agu_room && queue_room;
	assign issue_accept = issue_valid && issue_ready;

	for (genvar j = 0; j < N_AGU; j++) begin : g_chk
		assert property (@(posedge clk) disable iff (reset)
			ent[j].valid |-> int'(ent[j].pointer) < ((ent[j].kind == MEM_LOAD) ? N_LQ : N_SQ));
		// pointer tracking keeps us aimed at our own slot
		assert property (@(posedge clk) disable iff (reset)
			ent[j].valid |-> slot_addr[j] == ent[j].offset);
	end

endmodule

//--- hdl/store_queue.sv
`timescale 1ns/1ps

module store_queue import cpu_pkg::*, lsu_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  lsu_issue_t              issue,
	input  logic                    issue_accept,
	input  cdb_t                    cdb,
	input  agu_wb_t                 agu_wb,
	input  logic                    commit_valid,
	output logic                    commit_ready,
	output logic [SQ_PTR_WIDTH-1:0] sq_count,
	output logic                    sq_commit,
	output store_entry_t            sq_entries [N_SQ],
	output logic                    mem_we,
	output logic [ADDR_WIDTH-1:0]   mem_waddr,
	output logic [DATA_WIDTH-1:0]   mem_wdata
);

	store_entry_t upd [N_SQ];
	store_entry_t nxt [N_SQ];
	store_entry_t new_entry;
	logic enqueue;

	assign enqueue = issue_accept && issue.kind == MEM_STORE;

	always_comb begin
		new_entry.addr_valid = issue.imm_addr;
		new_entry.addr       = issue.addr_imm;
		new_entry.data       = wake(issue.store_data, cdb);
	end

	always_comb begin
		for (int j = 0; j < N_SQ; j++) begin
			upd[j]      = sq_entries[j];
			upd[j].data = wake(sq_entries[j].data, cdb);
			if (agu_wb.valid && agu_wb.kind == MEM_STORE && agu_wb.slot == SQ_PTR_WIDTH'(j)) begin
				upd[j].addr_valid = 1'b1;
				upd[j].addr       = agu_wb.addr;
			end
		end
	end

	// head leaves on commit, the rest slide down
	always_comb begin
		int src;
		for (int j = 0; j < N_SQ; j++) begin
			src    = j + int'(sq_commit);
			nxt[j] = (src < int'(sq_count)) ? upd[src] : new_entry;
		end
	end

	always_ff @(posedge clk) begin
		sq_entries <= nxt;
		if (reset)
			sq_count <= '0;
		else
			sq_count <= sq_count - SQ_PTR_WIDTH'(sq_commit) + SQ_PTR_WIDTH'(enqueue);
	end

	assign commit_ready = sq_count != '0 && sq_entries[0].addr_valid;
	assign sq_commit    = commit_valid && commit_ready;

	assign mem_we    = sq_commit;
	assign mem_waddr = sq_entries[0].addr;
	assign mem_wdata = sq_entries[0].data.data;

	// the ROB must not commit a store before its data arrives
	assert property (@(posedge clk) disable iff (reset)
		sq_commit |-> sq_entries[0].data.valid);

endmodule

//--- hdl/load_queue.sv
`timescale 1ns/1ps

module load_queue import cpu_pkg::*, lsu_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  lsu_issue_t              issue,
	input  logic                    issue_accept,
	input  agu_wb_t                 agu_wb,
	input  logic [SQ_PTR_WIDTH-1:0] sq_count,
	input  logic                    sq_commit,
	input  store_entry_t            sq_entries [N_SQ],
	input  logic [DATA_WIDTH-1:0]   mem_rdata,
	input  logic                    result_ready,
	output logic                    lq_room,
	output logic [LQ_PTR_WIDTH:0]   lq_count,
	output logic                    lq_dequeue,
	output logic [ADDR_WIDTH-1:0]   lq_base_addr [N_LQ],
	output logic [ADDR_WIDTH-1:0]   mem_raddr,
	output cdb_t                    result
);

	load_entry_t lq [N_LQ];
	load_entry_t upd [N_LQ];
	load_entry_t nxt [N_LQ];
	load_entry_t new_entry;
	logic enqueue;
	logic stores_done;
	logic [DATA_WIDTH-1:0] fwd_data;

	assign enqueue = issue_accept && issue.kind == MEM_LOAD;

	always_comb begin
		new_entry.tag          = issue.dest;
		new_entry.addr_valid   = issue.imm_addr;
		new_entry.addr         = issue.addr_imm;
		new_entry.older_stores = sq_count - SQ_PTR_WIDTH'(sq_commit);
	end

	always_comb begin
		for (int j = 0; j < N_LQ; j++) begin
			upd[j] = lq[j];
			if (agu_wb.valid && agu_wb.kind == MEM_LOAD && agu_wb.slot == SQ_PTR_WIDTH'(j)) begin
				upd[j].addr_valid = 1'b1;
				upd[j].addr       = agu_wb.addr;
			end
			if (sq_commit && lq[j].older_stores != '0)
				upd[j].older_stores = lq[j].older_stores - SQ_PTR_WIDTH'(1);
		end
	end

	// compact toward slot 0
	always_comb begin
		int src;
		for (int j = 0; j < N_LQ; j++) begin
			src    = j + int'(lq_dequeue);
			nxt[j] = (src < int'(lq_count)) ? upd[src] : new_entry;
		end
	end

	always_ff @(posedge clk) begin
		lq <= nxt;
		if (reset)
			lq_count <= '0;
		else
			lq_count <= lq_count - (LQ_PTR_WIDTH+1)'(lq_dequeue) + (LQ_PTR_WIDTH+1)'(enqueue);
	end

	// older stores sit in slots below the head's count
	always_comb begin
		stores_done = 1'b1;
		fwd_data    = mem_rdata;
		for (int j = 0; j < N_SQ; j++) begin
			if (SQ_PTR_WIDTH'(j) < lq[0].older_stores) begin
				if (!(sq_entries[j].addr_valid && sq_entries[j].data.valid))
					stores_done = 1'b0;
				if (sq_entries[j].addr == lq[0].addr)
					fwd_data = sq_entries[j].data.data;  // youngest match wins
			end
		end
	end

	assign result.valid = lq_count != '0 && lq[0].addr_valid && stores_done;
	assign result.tag   = lq[0].tag;
	assign result.data  = fwd_data;

	assign lq_dequeue = result.valid && result_ready;
	assign lq_room    = int'(lq_count) < N_LQ || lq_dequeue;
	assign mem_raddr  = nxt[0].addr;  // word is ready when this becomes the head

	always_comb begin
		for (int j = 0; j < N_LQ; j++)
			lq_base_addr[j] = lq[j].addr;
	end

	assert property (@(posedge clk) disable iff (reset)
		result.valid && !result_ready |=> result.valid && $stable(result));

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/1ps

module data_mem import cpu_pkg::*, lsu_pkg::*; (
	input  logic                  clk,
	input  logic                  we,
	input  logic [ADDR_WIDTH-1:0] waddr,
	input  logic [DATA_WIDTH-1:0] wdata,
	input  logic [ADDR_WIDTH-1:0] raddr,
	output logic [DATA_WIDTH-1:0] rdata
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		if (we && waddr == raddr)
			rdata <= wdata;  // write-first
		else
			rdata <= mem[raddr];
	end

endmodule

//--- hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import cpu_pkg::*, lsu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  lsu_issue_t issue,
	input  logic       issue_valid,
	output logic       issue_ready,
	input  cdb_t       cdb,
	output cdb_t       result,
	input  logic       result_ready,
	input  logic       commit_valid,
	output logic       commit_ready
);

	logic issue_accept;
	agu_wb_t agu_wb;
	logic lq_room;
	logic sq_room;
	logic [LQ_PTR_WIDTH:0] lq_count;
	logic [SQ_PTR_WIDTH-1:0] sq_count;
	logic lq_dequeue;
	logic sq_commit;
	logic [ADDR_WIDTH-1:0] lq_base_addr [N_LQ];
	store_entry_t sq_entries [N_SQ];
	logic mem_we;
	logic [ADDR_WIDTH-1:0] mem_waddr;
	logic [DATA_WIDTH-1:0] mem_wdata;
	logic [ADDR_WIDTH-1:0] mem_raddr;
	logic [DATA_WIDTH-1:0] mem_rdata;

	// sq_room is the only signal not produced by a block below
	assign sq_room = int'(sq_count) < N_SQ || sq_commit;

	addr_gen_unit u_agu (
		.clk          (clk),
		.reset        (reset),
		.issue        (issue),
		.issue_valid  (issue_valid),
		.cdb          (cdb),
		.lq_room      (lq_room),
		.sq_room      (sq_room),
		.lq_count     (lq_count),
		.sq_count     (sq_count),
		.lq_dequeue   (lq_dequeue),
		.sq_commit    (sq_commit),
		.lq_base_addr (lq_base_addr),
		.sq_entries   (sq_entries),
		.issue_ready  (issue_ready),
		.issue_accept (issue_accept),
		.agu_wb       (agu_wb)
	);

	store_queue u_sq (
		.clk          (clk),
		.reset        (reset),
		.issue        (issue),
		.issue_accept (issue_accept),
		.cdb          (cdb),
		.agu_wb       (agu_wb),
		.commit_valid (commit_valid),
		.commit_ready (commit_ready),
		.sq_count     (sq_count),
		.sq_commit    (sq_commit),
		.sq_entries   (sq_entries),
		.mem_we       (mem_we),
		.mem_waddr    (mem_waddr),
		.mem_wdata    (mem_wdata)
	);

	load_queue u_lq (
		.clk          (clk),
		.reset        (reset),
		.issue        (issue),
		.issue_accept (issue_accept),
		.agu_wb       (agu_wb),
		.sq_count     (sq_count),
		.sq_commit    (sq_commit),
		.sq_entries   (sq_entries),
		.mem_rdata    (mem_rdata),
		.result_ready (result_ready),
		.lq_room      (lq_room),
		.lq_count     (lq_count),
		.lq_dequeue   (lq_dequeue),
		.lq_base_addr (lq_base_addr),
		.mem_raddr    (mem_raddr),
		.result       (result)
	);

	data_mem u_mem (
		.clk   (clk),
		.we    (mem_we),
		.waddr (mem_waddr),
		.wdata (mem_wdata),
		.raddr (mem_raddr),
		.rdata (mem_rdata)
	);

endmodule

//--- testbench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import cpu_pkg::*, lsu_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE        = 2;  // input skew after the rising edge
	localparam int RESET_CYCLES = 10;
	localparam int N_RANDOM     = 80;
	// cycle budgets: reset, store/load, forward, pending, back-pressure, random mix
	localparam int TEST_CYCLES  = 20 + 200 + 100 + 200 + 400 + N_RANDOM * 40;
	localparam int MARGIN       = 500;

	logic       clk = 1'b0;
	logic       reset;
	lsu_issue_t issue;
	logic       issue_valid;
	logic       issue_ready;
	cdb_t       cdb;
	cdb_t       result;
	logic       result_ready;
	logic       commit_valid;
	logic       commit_ready;

	logic [DATA_WIDTH-1:0] model_mem [2**ADDR_WIDTH];
	bit                    written [2**ADDR_WIDTH];
	cdb_t     exp_q [$];   // expected load results in program order
	cdb_t     pend_q [$];  // broadcasts still owed to waiting operands
	cdb_t     last_result;
	logic     held = 1'b0;
	logic     rand_ready = 1'b0;
	int       errors = 0;
	int       checks = 0;
	int       results_seen = 0;
	int       sq_used = 0;  // issued, not yet committed
	int       test_errors = 0;
	rob_tag_t next_dest = '0;
	rob_tag_t next_wait = '0;

	lsu_top dut (.*);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// stores update the model in program order, loads read it
	function automatic logic [DATA_WIDTH-1:0] expected_load(input mem_kind_t kind,
			input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] st_data);
		if (kind == MEM_STORE) begin
			model_mem[addr] = st_data;
			written[addr]   = 1'b1;
		end
		return model_mem[addr];
	endfunction

	function automatic cdb_t operand(input logic [DATA_WIDTH-1:0] d, input logic pend);
		cdb_t o;
		cdb_t b;
		o.valid = !pend;
		o.tag   = next_wait;
		o.data  = d;
		if (pend) begin
			b       = o;
			b.valid = 1'b1;
			pend_q.push_back(b);
			next_wait++;
		end
		return o;
	endfunction

	task automatic send(input lsu_issue_t op, input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] st_data);
		cdb_t e;
		issue       = op;
		issue_valid = 1'b1;
		@(negedge clk);
		while (!issue_ready)
			@(negedge clk);
		e.valid = 1'b1;
		e.tag   = op.dest;
		e.data  = expected_load(op.kind, addr, st_data);
		if (op.kind == MEM_LOAD)
			exp_q.push_back(e);
		else
			sq_used++;
		@(posedge clk);
		#DRIVE;
		issue_valid = 1'b0;
	endtask

	task automatic do_store(input int addr, input logic [DATA_WIDTH-1:0] d, input logic based,
			input logic base_pend, input logic data_pend, input int off);
		lsu_issue_t op;
		op.kind       = MEM_STORE;
		op.imm_addr   = !based;
		op.addr_imm   = based ? ADDR_WIDTH'(off) : ADDR_WIDTH'(addr);
		op.base       = operand(DATA_WIDTH'(ADDR_WIDTH'(addr - off)), based && base_pend);
		op.store_data = operand(d, data_pend);
		op.dest       = '0;
		send(op, ADDR_WIDTH'(addr), d);
	endtask

	task automatic do_load(input int addr, input logic based, input logic base_pend,
			input int off);
		lsu_issue_t op;
		op.kind       = MEM_LOAD;
		op.imm_addr   = !based;
		op.addr_imm   = based ? ADDR_WIDTH'(off) : ADDR_WIDTH'(addr);
		op.base       = operand(DATA_WIDTH'(ADDR_WIDTH'(addr - off)), based && base_pend);
		op.store_data = '0;
		op.dest       = next_dest;
		next_dest++;
		send(op, ADDR_WIDTH'(addr), '0);
	endtask

	task automatic broadcast_one();
		cdb = pend_q.pop_front();
		@(posedge clk);
		#DRIVE;
		cdb.valid = 1'b0;
	endtask

	task automatic broadcast_newest();
		cdb = pend_q.pop_back();
		@(posedge clk);
		#DRIVE;
		cdb.valid = 1'b0;
	endtask

	task automatic broadcast_all();
		while (pend_q.size() != 0)
			broadcast_one();
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#DRIVE;
		end
	endtask

	// older loads retire before the rob lets a store go
	task automatic commit_one();
		broadcast_all();
		drain();
		commit_valid = 1'b1;
		@(negedge clk);
		while (!commit_ready)
			@(negedge clk);
		sq_used--;
		@(posedge clk);
		#DRIVE;
		commit_valid = 1'b0;
	endtask

	task automatic commit_all();
		while (sq_used != 0)
			commit_one();
	endtask

	task automatic expect_no_result(input int n);
		repeat (n) begin
			@(negedge clk);
			check_value("result.valid", 64'(result.valid), 64'h0);
		end
		@(posedge clk);
		#DRIVE;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	always @(posedge clk) begin
		#DRIVE;
		result_ready = rand_ready ? (($urandom % 3) != 0) : 1'b1;
	end

	// compare every fired result, and hold-steady while stalled
	always @(negedge clk) begin
		if (!reset) begin
			if (held) begin
				check_value("result.valid", 64'(result.valid), 64'h1);
				check_value("result.tag", 64'(result.tag), 64'(last_result.tag));
				check_value("result.data", 64'(result.data), 64'(last_result.data));
			end
			if (result.valid && result_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("load result with tag %h came with no load outstanding", result.tag);
				end else begin
					check_value("result.tag", 64'(result.tag), 64'(exp_q[0].tag));
					check_value("result.data", 64'(result.data), 64'(exp_q[0].data));
					exp_q.delete(0);
					results_seen++;
				end
			end
			held        = result.valid && !result_ready;
			last_result = result;
		end
	end

	initial begin
		#((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d cycles",
			RESET_CYCLES + TEST_CYCLES + MARGIN);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int addr;
		int off;
		logic [31:0] r;
		void'($urandom(32'hdb8d_5655));
		reset        = 1'b1;
		issue        = '0;
		issue_valid  = 1'b0;
		cdb          = '0;
		result_ready = 1'b1;
		commit_valid = 1'b0;

		fork
			begin
				repeat (RESET_CYCLES) @(posedge clk);
				#DRIVE;
				reset = 1'b0;
			end
			repeat (RESET_CYCLES + 2) begin
				@(negedge clk);
				check_value("result.valid", 64'(result.valid), 64'h0);
				check_value("commit_ready", 64'(commit_ready), 64'h0);
				check_value("issue_ready", 64'(issue_ready), 64'h1);
			end
		join
		@(posedge clk);
		#DRIVE;
		end_test("reset");

		for (int i = 0; i < 4; i++)
			do_store(16 + i, 32'h1000_0000 + i * 32'h111, 1'b0, 1'b0, 1'b0, 0);
		commit_all();
		for (int i = 0; i < 4; i++)
			do_load(16 + i, 1'b0, 1'b0, 0);
		drain();
		end_test("store_then_load");

		do_store(40, 32'hcafe_0040, 1'b0, 1'b0, 1'b0, 0);
		do_load(40, 1'b0, 1'b0, 0);
		do_load(17, 1'b0, 1'b0, 0);
		drain();  // results in before the store commits
		commit_all();
		end_test("forwarding");

		do_store(105, 32'haaaa_0105, 1'b1, 1'b1, 1'b0, 5);
		do_store(110, 32'h0000_1234, 1'b0, 1'b0, 1'b1, 0);
		do_load(110, 1'b1, 1'b1, -2);  // youngest older match
		do_load(105, 1'b0, 1'b0, 0);
		expect_no_result(6);
		broadcast_one();
		broadcast_newest();  // head load gets its address
		expect_no_result(4);  // second store still lacks data
		broadcast_all();
		drain();
		commit_all();
		do_load(105, 1'b1, 1'b0, 9);
		do_load(110, 1'b0, 1'b0, 0);
		drain();
		end_test("pending_operands");

		rand_ready = 1'b1;
		for (int i = 0; i < 12; i++)
			do_load((i % 3 == 0) ? 40 : 16 + i % 4, 1'b0, 1'b0, 0);
		drain();
		for (int i = 0; i < N_SQ; i++)
			do_store(120 + i, 32'hbeef_0000 + i, 1'b0, 1'b0, 1'b0, 0);
		fork
			do_store(124, 32'hbeef_0004, 1'b0, 1'b0, 1'b0, 0);
			begin
				repeat (4) begin
					@(negedge clk);
					check_value("issue_ready", 64'(issue_ready), 64'h0);
				end
				@(posedge clk);
				#DRIVE;
				commit_one();
			end
		join
		commit_all();
		end_test("back_pressure");

		for (int n = 0; n < N_RANDOM; n++) begin
			r    = $urandom;
			addr = 200 + int'($urandom % 8);
			off  = int'($urandom % 16) - 8;
			if (pend_q.size() >= 2)
				broadcast_all();
			if (!written[addr] || r[4:3] == 2'b00) begin
				if (sq_used == N_SQ)
					commit_one();
				do_store(addr, $urandom, r[0], r[1], r[2], off);
			end else begin
				if (exp_q.size() >= N_LQ)
					broadcast_all();  // a full queue may wait on these
				do_load(addr, r[0], r[1], off);
			end
			if (r[5] && pend_q.size() != 0)
				broadcast_one();
			if (r[8:6] == 3'b000 && sq_used != 0)
				commit_one();
		end
		broadcast_all();
		drain();
		commit_all();
		rand_ready = 1'b0;
		end_test("random_mix");

		$display("%0d checks, %0d errors, %0d load results", checks, errors, results_seen);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- lsu_top.f
hdl/cpu_pkg.sv
hdl/lsu_pkg.sv
hdl/addr_gen_unit.sv
hdl/store_queue.sv
hdl/load_queue.sv
hdl/data_mem.sv
hdl/lsu_top.sv
testbench/lsu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := lsu_tb
RTL_TOP    := lsu_top
FILELIST   := lsu_top.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
